// ==== compile.f ====
design/kvs_shell_pkg.sv
design/stream_fifo.sv
design/listen_port_opener.sv
design/trailer_inject.sv
design/tx_frame_ctrl.sv
design/kvs_net_shell.sv
tb/shell_checker.sv
tb/tb_top.sv

// ==== design/kvs_net_shell.sv ====
//--------------------
// top level of the key-value store network shell on the TCP offload engine
// opens the listen ports, buffers rx and frames the tx response stream
//--------------------
`timescale 1ns/1ps

module kvs_net_shell #(
   parameter int rx_addr_bits = 5,
   parameter int tx_addr_bits = 9
) (
   input  logic                                aclk,
   input  logic                                aresetn,

   // receive stream from the engine
   input  logic                                rx_valid,
   output logic                                rx_ready,
   input  kvs_shell_pkg::net_beat_t            rx_beat,

   // request beats towards the application
   output logic                                req_valid,
   input  logic                                req_ready,
   output kvs_shell_pkg::net_beat_t            req_beat,

   // response beats from the application
   input  logic                                resp_valid,
   output logic                                resp_ready,
   input  kvs_shell_pkg::app_beat_t            resp_beat,

   // transmit data and metadata towards the engine
   output logic                                tx_data_valid,
   input  logic                                tx_data_ready,
   output kvs_shell_pkg::net_beat_t            tx_data_beat,
   output logic                                tx_meta_valid,
   input  logic                                tx_meta_ready,
   output logic [kvs_shell_pkg::tx_meta_w-1:0] tx_meta,

   // listen-port requests
   output logic                                listen_valid,
   output logic [kvs_shell_pkg::port_w-1:0]    listen_port,
   input  logic                                listen_ready
);

   import kvs_shell_pkg::*;

   // injector output into the transmit buffer
   logic      inj_valid;
   logic      inj_ready;
   app_beat_t inj_beat;

   // transmit buffer output into the framer
   logic      txq_valid;
   logic      txq_ready;
   app_beat_t txq_beat;

   listen_port_opener u_opener (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .listen_ready (listen_ready),
      .listen_valid (listen_valid),
      .listen_port  (listen_port)
   );

   // -------------------
   // receive path
   // -------------------

   stream_fifo #(
      .payload_t (net_beat_t),
      .addr_bits (rx_addr_bits)
   ) rx_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (rx_valid),
      .in_ready  (rx_ready),
      .in_beat   (rx_beat),
      .out_valid (req_valid),
      .out_ready (req_ready),
      .out_beat  (req_beat)
   );

   // -------------------
   // transmit path
   // -------------------

   trailer_inject u_trailer (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_beat  (resp_beat),
      .out_valid  (inj_valid),
      .out_ready  (inj_ready),
      .out_beat   (inj_beat)
   );

   stream_fifo #(
      .payload_t (app_beat_t),
      .addr_bits (tx_addr_bits)
   ) tx_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (inj_valid),
      .in_ready  (inj_ready),
      .in_beat   (inj_beat),
      .out_valid (txq_valid),
      .out_ready (txq_ready),
      .out_beat  (txq_beat)
   );

   tx_frame_ctrl u_framer (
      .aclk          (aclk),
      .aresetn       (aresetn),
      .in_valid      (txq_valid),
      .in_ready      (txq_ready),
      .in_beat       (txq_beat),
      .tx_data_valid (tx_data_valid),
      .tx_data_ready (tx_data_ready),
      .tx_data_beat  (tx_data_beat),
      .tx_meta_valid (tx_meta_valid),
      .tx_meta_ready (tx_meta_ready),
      .tx_meta       (tx_meta)
   );

endmodule

// ==== design/kvs_shell_pkg.sv ====
//--------------------
// shared widths, listen-port range and beat structs of the key-value network shell
// imported by every module that carries network or application beats
//--------------------

package kvs_shell_pkg;

   // -------------------
   // widths
   // -------------------

   // one network beat of the TCP stream
   localparam int net_data_w = 64;

   // metadata travelling with each application response beat
   localparam int app_meta_w = 64;

   // session word handed to the engine, taken from the low bits of the beat meta
   localparam int tx_meta_w = 16;

   localparam int port_w = 16;

   // -------------------
   // listen-port range
   // -------------------

   // ports 2880 up to 2887 are opened after reset
   localparam logic [port_w-1:0] first_listen_port = 16'd2880;
   localparam int listen_port_count = 8;

   // -------------------
   // beat structs
   // -------------------

   // receive stream and transmit data beat, 65 bits
   typedef struct packed {
      logic                  last;
      logic [net_data_w-1:0] data;
   } net_beat_t;

   // response beat from the application, 129 bits
   typedef struct packed {
      logic                  last;
      logic [app_meta_w-1:0] meta;
      logic [net_data_w-1:0] data;
   } app_beat_t;

endpackage

// ==== design/listen_port_opener.sv ====
//--------------------
// asks the offload engine to open the listen-port range once after reset
//--------------------
`timescale 1ns/1ps

module listen_port_opener (
   input  logic                              aclk,
   input  logic                              aresetn,

   input  logic                              listen_ready,
   output logic                              listen_valid,
   output logic [kvs_shell_pkg::port_w-1:0]  listen_port
);

   import kvs_shell_pkg::*;

   localparam int cnt_w = $clog2(listen_port_count + 1);

   logic [port_w-1:0] next_port;
   logic [cnt_w-1:0]  ports_left;

   // a strobe lasts one cycle and never waits for ready, so the next one
   // is only considered once the previous strobe has dropped
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         listen_valid <= 1'b0;
         next_port    <= first_listen_port;
         ports_left   <= cnt_w'(listen_port_count);
      end else begin
         listen_valid <= 1'b0;
         if (!listen_valid && listen_ready && (ports_left != '0)) begin
            listen_valid <= 1'b1;
            next_port    <= next_port + 1'b1;
            ports_left   <= ports_left - 1'b1;
         end
      end
   end

   // port number is only meaningful while the strobe is high
   always_ff @(posedge aclk) begin
      if (!listen_valid && listen_ready && (ports_left != '0)) begin
         listen_port <= next_port;
      end
   end

endmodule

// ==== design/stream_fifo.sv ====
//--------------------
// first-word-fall-through FIFO for any packed payload type
// the head entry is always visible on out_beat while out_valid is high
//--------------------
`timescale 1ns/1ps

module stream_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  addr_bits = 4
) (
   input  logic     aclk,
   input  logic     aresetn,

   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_beat,

   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_beat
);

   localparam int depth = 2 ** addr_bits;

   payload_t             mem [0:depth-1];
   logic [addr_bits-1:0] wr_ptr;
   logic [addr_bits-1:0] rd_ptr;
   // one bit wider than the pointers so that a full buffer can be told apart
   logic [addr_bits:0]   count;
   logic                 wr_en;
   logic                 rd_en;

   // the top bit of the count is set only when all entries are taken
   assign in_ready  = ~count[addr_bits];
   assign out_valid = (count != '0);
   assign out_beat  = mem[rd_ptr];

   assign wr_en = in_valid & in_ready;
   assign rd_en = out_valid & out_ready;

   always_ff @(posedge aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== design/trailer_inject.sv ====
//--------------------
// passes application response beats on and appends a one-beat trailer packet
// after every response packet, carrying the meta of its last beat
//--------------------
`timescale 1ns/1ps

module trailer_inject (
   input  logic                      aclk,
   input  logic                      aresetn,

   input  logic                      resp_valid,
   output logic                      resp_ready,
   input  kvs_shell_pkg::app_beat_t  resp_beat,

   output logic                      out_valid,
   input  logic                      out_ready,
   output kvs_shell_pkg::app_beat_t  out_beat
);

   import kvs_shell_pkg::*;

   logic                  trailer_pending;
   logic [app_meta_w-1:0] trailer_meta;
   app_beat_t             trailer_beat;

   assign trailer_beat.last = 1'b1;
   assign trailer_beat.meta = trailer_meta;
   assign trailer_beat.data = '0;

   // -------------------
   // output mux
   // -------------------

   // the trailer wins, the application is held off until it is accepted
   assign out_valid  = trailer_pending | resp_valid;
   assign out_beat   = trailer_pending ? trailer_beat : resp_beat;
   assign resp_ready = out_ready & ~trailer_pending;

   // -------------------
   // trailer state
   // -------------------

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         trailer_pending <= 1'b0;
      end else begin
         if (trailer_pending && out_ready) begin
            trailer_pending <= 1'b0;
         end
         // resp_ready is low while pending, so this cannot collide with the clear
         if (resp_valid && resp_ready && resp_beat.last) begin
            trailer_pending <= 1'b1;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (resp_valid && resp_ready && resp_beat.last) begin
         trailer_meta <= resp_beat.meta;
      end
   end

endmodule

// ==== design/tx_frame_ctrl.sv ====
//--------------------
// frames the transmit stream, one session metadata word per packet
// the first beat of a packet is held until the metadata slot is free
//--------------------
`timescale 1ns/1ps

module tx_frame_ctrl (
   input  logic                                aclk,
   input  logic                                aresetn,

   input  logic                                in_valid,
   output logic                                in_ready,
   input  kvs_shell_pkg::app_beat_t            in_beat,

   output logic                                tx_data_valid,
   input  logic                                tx_data_ready,
   output kvs_shell_pkg::net_beat_t            tx_data_beat,

   output logic                                tx_meta_valid,
   input  logic                                tx_meta_ready,
   output logic [kvs_shell_pkg::tx_meta_w-1:0] tx_meta
);

   import kvs_shell_pkg::*;

   logic first_beat;
   logic first_gate;
   logic data_fire;

   // -------------------
   // data path gating
   // -------------------

   // later beats of a packet only look at the engine's data ready
   assign first_gate = ~first_beat | (tx_meta_ready & ~tx_meta_valid);

   assign tx_data_valid = in_valid & first_gate;
   assign in_ready      = tx_data_ready & first_gate;
   assign data_fire     = in_valid & in_ready;

   // the engine takes no meta on the data channel
   assign tx_data_beat.last = in_beat.last;
   assign tx_data_beat.data = in_beat.data;

   // -------------------
   // packet tracking and metadata
   // -------------------

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         first_beat    <= 1'b1;
         tx_meta_valid <= 1'b0;
      end else begin
         if (tx_meta_valid && tx_meta_ready) begin
            tx_meta_valid <= 1'b0;
         end
         // first_gate keeps this from overlapping a pending metadata word
         if (data_fire && first_beat) begin
            tx_meta_valid <= 1'b1;
            first_beat    <= 1'b0;
         end
         // a one-beat packet sets the flag straight back
         if (data_fire && in_beat.last) begin
            first_beat <= 1'b1;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (data_fire && first_beat) begin
         tx_meta <= in_beat.meta[tx_meta_w-1:0];
      end
   end

endmodule

// ==== tb/shell_checker.sv ====
//--------------------
// watches the shell ports, models the expected streams and counts mismatches
// tb_top calls report_tests once the streams have drained
//--------------------
`timescale 1ns/1ps

module shell_checker #(
   parameter int n_rx  = 300,
   parameter int n_pkt = 60
) (
   input logic                                aclk,
   input logic                                aresetn,
   input logic                                rx_valid,
   input logic                                rx_ready,
   input kvs_shell_pkg::net_beat_t            rx_beat,
   input logic                                req_valid,
   input logic                                req_ready,
   input kvs_shell_pkg::net_beat_t            req_beat,
   input logic                                resp_valid,
   input logic                                resp_ready,
   input kvs_shell_pkg::app_beat_t            resp_beat,
   input logic                                tx_data_valid,
   input logic                                tx_data_ready,
   input kvs_shell_pkg::net_beat_t            tx_data_beat,
   input logic                                tx_meta_valid,
   input logic                                tx_meta_ready,
   input logic [kvs_shell_pkg::tx_meta_w-1:0] tx_meta,
   input logic                                listen_valid,
   input logic [kvs_shell_pkg::port_w-1:0]    listen_port,
   input logic                                listen_ready
);

   import kvs_shell_pkg::*;

   // the engine expects listen requests for 2880 up to 2887
   localparam int port_base  = 2880;
   localparam int port_total = 8;

   net_beat_t   exp_rx[$];
   net_beat_t   exp_tx[$];
   logic [15:0] exp_meta[$];

   int   listen_seen    = 0;
   int   rx_seen        = 0;
   int   resp_pkts      = 0;
   int   tx_seen        = 0;
   int   tx_starts      = 0;
   int   meta_seen      = 0;
   int   err_listen     = 0;
   int   err_rx         = 0;
   int   err_tx         = 0;
   int   err_meta       = 0;
   int   err_hold       = 0;
   logic listen_q       = 1'b0;
   logic listen_ready_q = 1'b0;
   logic resp_first     = 1'b1;
   logic out_first      = 1'b1;

   task automatic show_fail(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
   endtask

   // --------------------
   // reference model
   // --------------------

   // every response packet is followed by a one-beat trailer carrying its last meta
   task automatic model_resp();
      net_beat_t b;
      b.last = resp_beat.last;
      b.data = resp_beat.data;
      exp_tx.push_back(b);
      if (resp_first) exp_meta.push_back(resp_beat.meta[15:0]);
      resp_first = resp_beat.last;
      if (resp_beat.last) begin
         b.last = 1'b1;
         b.data = '0;
         exp_tx.push_back(b);
         exp_meta.push_back(resp_beat.meta[15:0]);
         resp_pkts++;
      end
   endtask

   // --------------------
   // comparisons
   // --------------------

   // a strobe follows every cycle that saw listen_ready high with the strobe low
   task automatic check_listen_timing();
      logic due;
      due = listen_ready_q && !listen_q && (listen_seen < port_total);
      if (listen_valid && !listen_ready_q) begin
         err_listen++;
         show_fail("listen strobe without listen_ready in the cycle before");
      end
      if (!listen_valid && due) begin
         err_listen++;
         show_fail("listen strobe missing after listen_ready");
      end
   endtask

   task automatic check_listen();
      if (listen_q) begin
         err_listen++;
         show_fail("listen strobes in two consecutive cycles");
      end
      if (listen_seen >= port_total) begin
         err_listen++;
         show_fail($sformatf("extra listen strobe for port %0d", listen_port));
      end else if (listen_port != 16'(port_base + listen_seen)) begin
         err_listen++;
         show_fail($sformatf("listen port %0d, expected %0d", listen_port,
                             port_base + listen_seen));
      end
      listen_seen++;
   endtask

   task automatic check_req();
      net_beat_t e;
      if (exp_rx.size() == 0) begin
         err_rx++;
         show_fail("request beat without a matching receive beat");
      end else begin
         e = exp_rx.pop_front();
         if (req_beat !== e) begin
            err_rx++;
            show_fail($sformatf("req beat %0d: last %0b data %h, expected last %0b data %h",
                                rx_seen, req_beat.last, req_beat.data, e.last, e.data));
         end
      end
      rx_seen++;
   endtask

   task automatic check_tx();
      net_beat_t e;
      if (exp_tx.size() == 0) begin
         err_tx++;
         show_fail("transmit beat without a matching response beat");
      end else begin
         e = exp_tx.pop_front();
         if (tx_data_beat !== e) begin
            err_tx++;
            show_fail($sformatf("tx beat %0d: last %0b data %h, expected last %0b data %h",
                                tx_seen, tx_data_beat.last, tx_data_beat.data, e.last, e.data));
         end
      end
      if (out_first) tx_starts++;
      out_first = tx_data_beat.last;
      tx_seen++;
   endtask

   task automatic check_meta();
      logic [15:0] e;
      if (meta_seen >= tx_starts) begin
         err_meta++;
         show_fail("metadata transferred before its packet started");
      end
      if (exp_meta.size() == 0) begin
         err_meta++;
         show_fail("metadata word without a matching packet");
      end else begin
         e = exp_meta.pop_front();
         if (tx_meta !== e) begin
            err_meta++;
            show_fail($sformatf("tx meta %0d: got %h, expected %h", meta_seen, tx_meta, e));
         end
      end
      meta_seen++;
   endtask

   always @(posedge aclk) begin
      if (aresetn) begin
         check_listen_timing();
         if (listen_valid) check_listen();
         listen_q       = listen_valid;
         listen_ready_q = listen_ready;
         if (rx_valid && rx_ready) exp_rx.push_back(rx_beat);
         if (req_valid && req_ready) check_req();
         if (resp_valid && resp_ready) model_resp();
         // a first beat goes out only with the metadata slot free and ready
         if (tx_data_valid && out_first && (tx_meta_valid || !tx_meta_ready)) begin
            err_hold++;
            show_fail("first beat offered while packet metadata is pending");
         end
         if (tx_data_valid && tx_data_ready) check_tx();
         if (tx_meta_valid && tx_meta_ready) check_meta();
      end
   end

   // --------------------
   // end of run
   // --------------------

   function automatic bit drained();
      return listen_seen >= port_total && rx_seen >= n_rx && resp_pkts >= n_pkt &&
             exp_rx.size() == 0 && exp_tx.size() == 0 && exp_meta.size() == 0;
   endfunction

   function automatic int error_total();
      return err_listen + err_rx + err_tx + err_meta + err_hold;
   endfunction

   task automatic report_one(input string name, input int errs);
      if (errs == 0) $display("test %s: passed", name);
      else $display("test %s: failed with %0d errors", name, errs);
   endtask

   task automatic report_tests();
      int passed;
      if (listen_seen != port_total) err_listen++;
      if (rx_seen != n_rx || exp_rx.size() != 0) err_rx++;
      if (resp_pkts != n_pkt || exp_tx.size() != 0) err_tx++;
      if (exp_meta.size() != 0 || meta_seen != tx_starts) err_meta++;
      report_one("listen ports", err_listen);
      report_one("receive stream", err_rx);
      report_one("transmit data", err_tx);
      report_one("transmit metadata", err_meta);
      report_one("first beat hold", err_hold);
      passed = (err_listen == 0) + (err_rx == 0) + (err_tx == 0) + (err_meta == 0) +
               (err_hold == 0);
      $display("summary: 5 tests, %0d passed, %0d failed, %0d errors", passed, 5 - passed,
               error_total());
   endtask

   // called by the watchdog to name the streams that never completed
   task automatic report_stalls();
      if (listen_seen != port_total)
         $display("listen ports did not finish, %0d of 8 requests seen", listen_seen);
      if (rx_seen != n_rx)
         $display("receive stream did not finish, %0d of %0d beats delivered", rx_seen, n_rx);
      if (resp_pkts != n_pkt || exp_tx.size() != 0)
         $display("transmit data did not finish, %0d beats still expected", exp_tx.size());
      if (exp_meta.size() != 0)
         $display("transmit metadata did not finish, %0d words still expected",
                  exp_meta.size());
   endtask

endmodule

// ==== tb/tb_top.sv ====
//--------------------
// testbench for the key-value network shell with random traffic on every channel
//--------------------
`timescale 1ns/1ps

module tb_top;

   import kvs_shell_pkg::*;

   localparam int n_rx        = 300;
   localparam int n_pkt       = 60;
   // 20 cycles per beat, counting the longest packets and their trailers
   localparam int watchdog_ns = 20 * (n_rx + n_pkt * 7) * 4 + 4000;

   logic                 aclk;
   logic                 aresetn;
   logic                 rx_valid;
   logic                 rx_ready;
   net_beat_t            rx_beat;
   logic                 req_valid;
   logic                 req_ready;
   net_beat_t            req_beat;
   logic                 resp_valid;
   logic                 resp_ready;
   app_beat_t            resp_beat;
   logic                 tx_data_valid;
   logic                 tx_data_ready;
   net_beat_t            tx_data_beat;
   logic                 tx_meta_valid;
   logic                 tx_meta_ready;
   logic [tx_meta_w-1:0] tx_meta;
   logic                 listen_valid;
   logic [port_w-1:0]    listen_port;
   logic                 listen_ready;

   integer seed;
   int     cyc        = 0;
   int     rx_sent    = 0;
   int     pkts_sent  = 0;
   int     beats_left = 0;
   logic   running    = 1'b0;
   logic   rx_taken   = 1'b0;
   logic   resp_taken = 1'b0;

   // small buffers so that the stalls below really fill them
   kvs_net_shell #(
      .rx_addr_bits (4),
      .tx_addr_bits (4)
   ) dut (.*);

   shell_checker #(
      .n_rx  (n_rx),
      .n_pkt (n_pkt)
   ) chk (.*);

   initial begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   always @(posedge aclk) begin
      running    <= aresetn;
      rx_taken   <= rx_valid & rx_ready;
      resp_taken <= resp_valid & resp_ready;
   end

   task automatic drive_inputs();
      logic eng_stall;
      logic app_stall;
      cyc++;
      if (!rx_valid || rx_taken) begin
         rx_valid = 1'b0;
         if (rx_sent < n_rx && ($random(seed) & 3) != 0) begin
            rx_valid     = 1'b1;
            rx_beat.data = {$random(seed), $random(seed)};
            rx_beat.last = (($random(seed) & 3) == 0);
            rx_sent++;
         end
      end
      if (!resp_valid || resp_taken) begin
         resp_valid = 1'b0;
         if (beats_left == 0 && pkts_sent < n_pkt) beats_left = 1 + (($random(seed) & 255) % 6);
         if (beats_left > 0 && ($random(seed) & 3) != 0) begin
            resp_valid     = 1'b1;
            resp_beat.meta = {$random(seed), $random(seed)};
            resp_beat.data = {$random(seed), $random(seed)};
            resp_beat.last = (beats_left == 1);
            beats_left--;
            if (resp_beat.last) pkts_sent++;
         end
      end
      // long stretches of back-pressure from the engine and from the application
      eng_stall     = (cyc % 500) >= 150 && (cyc % 500) < 300;
      app_stall     = (cyc % 350) >= 40 && (cyc % 350) < 120;
      tx_data_ready = !eng_stall && (($random(seed) & 3) != 0);
      tx_meta_ready = !eng_stall && (($random(seed) & 3) != 0);
      req_ready     = !app_stall && (($random(seed) & 3) != 0);
      listen_ready  = $random(seed) & 1;
   endtask

   always @(negedge aclk) begin
      if (running) drive_inputs();
   end

   initial begin
      seed          = 20454;
      aresetn       = 1'b0;
      rx_valid      = 1'b0;
      rx_beat       = '0;
      req_ready     = 1'b0;
      resp_valid    = 1'b0;
      resp_beat     = '0;
      tx_data_ready = 1'b0;
      tx_meta_ready = 1'b0;
      listen_ready  = 1'b0;
      repeat (10) @(posedge aclk);
      @(negedge aclk);
      aresetn = 1'b1;
      while (!(rx_sent == n_rx && pkts_sent == n_pkt && !rx_valid && !resp_valid &&
               chk.drained())) begin
         @(posedge aclk);
      end
      // wait a little longer so that a late extra strobe or beat is still caught
      repeat (20) @(posedge aclk);
      chk.report_tests();
      if (chk.error_total() == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("timeout at %0t ns, the streams did not drain", $time);
      chk.report_stalls();
      $display("=== FAIL ===");
      $finish;
   end

endmodule
